// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fcvt_tb
	@out="$$(./obj_dir/Vfcvt_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+tb
source/fcvt_pkg.sv
source/fp_rounding.sv
source/lzc.sv
source/f2i.sv
source/i2f.sv
source/credit_fifo.sv
source/fcvt_pipe.sv
source/fcvt_top.sv
tb/fcvt_tb.sv

// ==== source/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int DEPTH = 4
) (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic               push_i,
    input  wire fcvt_pkg::cvt_req_t push_data_i,
    input  wire logic               pop_i,
    output fcvt_pkg::cvt_req_t      head_o,
    output logic                    not_empty_o,
    output logic                    credit_o
);

    import fcvt_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cvt_req_t            mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;

    // the sender's credits keep the number of entries within DEPTH
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (!push_i && pop_i) begin
                count <= count - 1'b1;
            end
            credit_o <= pop_i;  // one credit back per freed slot
        end
    end

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = count != '0;

endmodule

`default_nettype wire

// ==== source/f2i.sv ====
`timescale 1ns/1ps
`default_nettype none

module f2i (
    input  wire fcvt_pkg::fp32_t          src_i,
    input  wire logic                     unsigned_i,
    input  wire fcvt_pkg::roundmode_e     rm_i,
    output logic [fcvt_pkg::XLEN-1:0]     result_o,
    output fcvt_pkg::fflags_t             flags_o
);

    import fcvt_pkg::*;

    // exponent at which the mantissa lsb weighs exactly one
    localparam logic [EXP_BITS-1:0] LPATH_EXP   = EXP_BITS'(EXP_BIAS + MAN_BITS);
    localparam logic [EXP_BITS-1:0] MAX_INT_EXP = EXP_BITS'(EXP_BIAS + INT_BITS - 1);
    localparam int                  SHIFT_W     = 2 * MAN_BITS + 3;

    logic                  exp_nz;
    logic [EXP_BITS-1:0]   exp_eff;
    logic [MAN_BITS:0]     mant;
    logic                  exp_of;
    logic                  sel_lpath;
    logic [EXP_BITS-1:0]   lpath_dist;
    logic [XLEN-1:0]       lpath_mag;
    logic [EXP_BITS-1:0]   rpath_dist;
    logic [4:0]            rpath_shamt;
    logic [SHIFT_W-1:0]    rpath_shift;
    logic [MAN_BITS:0]     rpath_int;
    logic                  rpath_guard;
    logic                  rpath_sticky;
    logic                  rpath_up;
    logic                  rpath_inexact;
    logic [XLEN-1:0]       rpath_mag;
    logic [XLEN-1:0]       mag;
    logic                  signed_of;
    logic                  neg_iv;
    logic                  iv;
    logic                  sel_max;
    logic [XLEN-1:0]       sat;

    // subnormals behave like exponent one without the hidden bit
    assign exp_nz  = |src_i.exp;
    assign exp_eff = src_i.exp | {{(EXP_BITS-1){1'b0}}, ~exp_nz};
    assign mant    = {exp_nz, src_i.man};

    assign exp_of    = exp_eff > MAX_INT_EXP;  // also catches infinity and NaN
    assign sel_lpath = exp_eff >= LPATH_EXP;

    assign lpath_dist = exp_eff - LPATH_EXP;
    assign lpath_mag  = XLEN'(mant) << lpath_dist[3:0];

    // shifts past the guard position only feed the sticky bit
    assign rpath_dist  = LPATH_EXP - exp_eff;
    assign rpath_shamt = (rpath_dist > EXP_BITS'(MAN_BITS + 2)) ? 5'(MAN_BITS + 2)
                                                                : rpath_dist[4:0];
    assign rpath_shift  = {mant, {(MAN_BITS+2){1'b0}}} >> rpath_shamt;
    assign rpath_int    = rpath_shift[SHIFT_W-1:MAN_BITS+2];
    assign rpath_guard  = rpath_shift[MAN_BITS+1];
    assign rpath_sticky = |rpath_shift[MAN_BITS:0];

    fp_rounding rounding (
        .sign_i    (src_i.sign),
        .guard_i   (rpath_guard),
        .sticky_i  (rpath_sticky),
        .lsb_i     (rpath_int[0]),
        .rm_i      (rm_i),
        .up_o      (rpath_up),
        .inexact_o (rpath_inexact)
    );

    assign rpath_mag = XLEN'(rpath_int) + XLEN'(rpath_up);
    assign mag       = sel_lpath ? lpath_mag : rpath_mag;

    // only -2^31 fits on the negative side at full magnitude
    assign signed_of = ~unsigned_i & (src_i.sign ? (mag > {1'b1, {(XLEN-1){1'b0}}})
                                                 : mag[XLEN-1]);
    assign neg_iv    = unsigned_i & src_i.sign & (|mag);
    assign iv        = exp_of | signed_of | neg_iv;

    assign sel_max = is_nan_f(src_i) | ~src_i.sign;
    assign sat     = sel_max ? {unsigned_i, {(XLEN-1){1'b1}}}
                             : {~unsigned_i, {(XLEN-1){1'b0}}};

    always_comb begin
        if (iv) begin
            result_o = sat;
        end else if (src_i.sign && !unsigned_i) begin
            result_o = -mag;
        end else begin
            result_o = mag;
        end
    end

    assign flags_o = '{nv: iv, nx: ~iv & ~sel_lpath & rpath_inexact, default: 1'b0};

endmodule

`default_nettype wire

// ==== source/fcvt_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcvt_pipe #(
    parameter int OUT_CREDITS = 2
) (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire fcvt_pkg::cvt_req_t head_i,
    input  wire logic               not_empty_i,
    output logic                    pop_o,
    input  wire logic               rsp_credit_i,
    output logic                    rsp_valid_o,
    output fcvt_pkg::cvt_rsp_t      rsp_o
);

    import fcvt_pkg::*;

    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [CRD_W-1:0]  credits;
    logic              issue;
    logic              s1_valid;
    cvt_req_t          s1_req;
    logic [XLEN-1:0]   f2i_result;
    fflags_t           f2i_flags;
    fp32_t             i2f_result;
    fflags_t           i2f_flags;
    logic              is_f2i;
    cvt_rsp_t          rsp_d;

    assign issue = not_empty_i & (credits != '0);
    assign pop_o = issue;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else if (issue && !rsp_credit_i) begin
            credits <= credits - 1'b1;
        end else if (!issue && rsp_credit_i) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            s1_valid    <= issue;
            rsp_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            s1_req <= head_i;
        end
        if (s1_valid) begin
            rsp_o <= rsp_d;
        end
    end

    f2i f2i_inst (
        .src_i      (s1_req.src),
        .unsigned_i (s1_req.op == F2I_U),
        .rm_i       (s1_req.rm),
        .result_o   (f2i_result),
        .flags_o    (f2i_flags)
    );

    i2f i2f_inst (
        .src_i      (s1_req.src),
        .unsigned_i (s1_req.op == I2F_U),
        .rm_i       (s1_req.rm),
        .result_o   (i2f_result),
        .flags_o    (i2f_flags)
    );

    assign is_f2i = (s1_req.op == F2I_S) || (s1_req.op == F2I_U);

    always_comb begin
        if (is_f2i) begin
            rsp_d.result   = f2i_result;
            rsp_d.flags    = f2i_flags;
            rsp_d.flags.nv = f2i_flags.nv | is_nan_f(s1_req.src);  // any NaN source is invalid
        end else begin
            rsp_d.result = i2f_result;
            rsp_d.flags  = i2f_flags;
        end
    end

endmodule

`default_nettype wire

// ==== source/fcvt_pkg.sv ====
`default_nettype none

package fcvt_pkg;

    localparam int EXP_BITS = 8;
    localparam int MAN_BITS = 23;
    localparam int EXP_BIAS = 127;
    localparam int INT_BITS = 32;
    localparam int XLEN     = 32;

    typedef struct packed {
        logic                sign;
        logic [EXP_BITS-1:0] exp;
        logic [MAN_BITS-1:0] man;
    } fp32_t;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } roundmode_e;

    // same bit order as the fflags CSR with nv in the msb
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [1:0] {
        F2I_S = 2'd0,
        F2I_U = 2'd1,
        I2F_S = 2'd2,
        I2F_U = 2'd3
    } cvt_op_e;

    typedef struct packed {
        cvt_op_e           op;
        roundmode_e        rm;
        logic [XLEN-1:0]   src;  // float bits or integer depending on op
    } cvt_req_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        fflags_t         flags;
    } cvt_rsp_t;

    function automatic logic is_nan_f(input fp32_t f);
        logic exp_all;
        logic man_nz;
        exp_all = &f.exp;
        man_nz  = |f.man;
        return exp_all & man_nz;
    endfunction

endpackage

`default_nettype wire

// ==== source/fcvt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcvt_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic               clk,
    input  wire logic               arst_n_i,
    input  wire logic               req_valid_i,
    input  wire fcvt_pkg::cvt_req_t req_i,
    output logic                    req_credit_o,
    input  wire logic               rsp_credit_i,
    output logic                    rsp_valid_o,
    output fcvt_pkg::cvt_rsp_t      rsp_o
);

    import fcvt_pkg::*;

    cvt_req_t head;
    logic     not_empty;
    logic     pop;

    credit_fifo #(.DEPTH(QUEUE_DEPTH)) fifo_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (req_valid_i),
        .push_data_i (req_i),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .credit_o    (req_credit_o)
    );

    fcvt_pipe #(.OUT_CREDITS(OUT_CREDITS)) pipe_inst (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .head_i       (head),
        .not_empty_i  (not_empty),
        .pop_o        (pop),
        .rsp_credit_i (rsp_credit_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

`default_nettype wire

// ==== source/fp_rounding.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_rounding (
    input  wire logic                sign_i,
    input  wire logic                guard_i,
    input  wire logic                sticky_i,
    input  wire logic                lsb_i,
    input  wire fcvt_pkg::roundmode_e rm_i,
    output logic                     up_o,
    output logic                     inexact_o
);

    import fcvt_pkg::*;

    logic inexact;

    assign inexact   = guard_i | sticky_i;
    assign inexact_o = inexact;

    always_comb begin
        case (rm_i)
            RNE: begin
                up_o = guard_i & (sticky_i | lsb_i);  // ties go to the even value
            end
            RTZ: begin
                up_o = 1'b0;
            end
            RDN: begin
                up_o = sign_i & inexact;  // magnitude grows toward minus infinity
            end
            RUP: begin
                up_o = ~sign_i & inexact;
            end
            RMM: begin
                up_o = guard_i;  // ties away from zero
            end
            default: begin
                up_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/i2f.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2f (
    input  wire logic [fcvt_pkg::XLEN-1:0] src_i,
    input  wire logic                      unsigned_i,
    input  wire fcvt_pkg::roundmode_e      rm_i,
    output fcvt_pkg::fp32_t                result_o,
    output fcvt_pkg::fflags_t              flags_o
);

    import fcvt_pkg::*;

    localparam int                  LZ_W     = $clog2(INT_BITS);
    localparam logic [EXP_BITS-1:0] EXP_TOP  = EXP_BITS'(EXP_BIAS + INT_BITS - 1);
    localparam int                  GRD_POS  = INT_BITS - MAN_BITS - 2;

    logic                  sign;
    logic [INT_BITS-1:0]   mag;
    logic [INT_BITS-1:0]   norm;
    logic [LZ_W-1:0]       lz;
    logic                  empty;
    logic                  guard;
    logic                  sticky;
    logic                  up;
    logic                  inexact;
    logic [MAN_BITS:0]     rounded;
    logic [EXP_BITS-1:0]   exp_raw;

    assign sign = src_i[INT_BITS-1] & ~unsigned_i;
    assign mag  = sign ? -src_i : src_i;  // 0x80000000 maps onto itself

    lzc #(.WIDTH(INT_BITS)) lzc_inst (
        .in_i    (mag),
        .cnt_o   (lz),
        .empty_o (empty)
    );

    assign norm = mag << lz;  // leading one lands in the msb and is dropped

    assign guard  = norm[GRD_POS];
    assign sticky = |norm[GRD_POS-1:0];

    fp_rounding rounding (
        .sign_i    (sign),
        .guard_i   (guard),
        .sticky_i  (sticky),
        .lsb_i     (norm[GRD_POS+1]),
        .rm_i      (rm_i),
        .up_o      (up),
        .inexact_o (inexact)
    );

    assign rounded = {1'b0, norm[INT_BITS-2 -: MAN_BITS]} + (MAN_BITS+1)'(up);

    // a carry out leaves an all-zero mantissa and bumps the exponent
    assign exp_raw = EXP_TOP - EXP_BITS'(lz) + EXP_BITS'(rounded[MAN_BITS]);

    always_comb begin
        if (empty) begin
            result_o = '0;
        end else begin
            result_o = '{sign: sign, exp: exp_raw, man: rounded[MAN_BITS-1:0]};
        end
    end

    assign flags_o = '{nx: inexact, default: 1'b0};

endmodule

`default_nettype wire

// ==== source/lzc.sv ====
`timescale 1ns/1ps
`default_nettype none

module lzc #(
    parameter int WIDTH = 32
) (
    input  wire logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0]      cnt_o,
    output logic                          empty_o
);

    localparam int CNT_W = $clog2(WIDTH);

    always_comb begin
        cnt_o = '0;
        // scan upward so the highest set bit decides the count
        for (int i = 0; i < WIDTH; i++) begin
            if (in_i[i]) begin
                cnt_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

    assign empty_o = ~|in_i;  // count is meaningless when this is set

endmodule

`default_nettype wire

// ==== tb/fcvt_model.svh ====
`ifndef FCVT_MODEL_SVH
`define FCVT_MODEL_SVH

function automatic logic model_round_up(input logic sign, input logic guard,
                                        input logic sticky, input logic lsb,
                                        input roundmode_e rm);
    case (rm)
        RNE: return guard && (sticky || lsb);
        RDN: return sign && (guard || sticky);
        RUP: return !sign && (guard || sticky);
        RMM: return guard;
        default: return 1'b0;
    endcase
endfunction

function automatic cvt_rsp_t ref_f2i(input logic [31:0] bits, input logic uns,
                                     input roundmode_e rm);
    longint unsigned m;
    longint unsigned ip;
    longint unsigned mag;
    int              e;
    int              d;
    logic            sgn;
    logic            g;
    logic            s;
    logic            inexact;
    logic            iv;
    logic            nan;
    cvt_rsp_t        r;
    sgn     = bits[31];
    e       = int'(bits[30:23]);
    m       = longint'(bits[22:0]);
    nan     = (bits[30:23] == 8'hFF) && (bits[22:0] != 0);
    inexact = 1'b0;
    mag     = 0;
    if (e != 0) begin
        m = m | (64'd1 << 23);  // hidden bit
    end else begin
        e = 1;
    end
    if (bits[30:23] == 8'hFF) begin
        iv = 1'b1;
    end else begin
        if (e >= 150) begin
            mag = (e > 158) ? (64'd1 << 40) : (m << (e - 150));
        end else begin
            d       = (150 - e > 40) ? 40 : 150 - e;
            ip      = m >> d;
            g       = ((m >> (d - 1)) & 64'd1) != 0;
            s       = (m & ((64'd1 << (d - 1)) - 1)) != 0;
            inexact = g | s;
            mag     = ip + longint'(model_round_up(sgn, g, s, ip[0], rm));
        end
        if (uns) begin
            iv = sgn ? (mag != 0) : (mag > 64'hFFFF_FFFF);
        end else begin
            iv = sgn ? (mag > 64'h8000_0000) : (mag >= 64'h8000_0000);
        end
    end
    if (iv) begin
        if (nan || !sgn) begin
            r.result = uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
        end else begin
            r.result = uns ? 32'h0 : 32'h8000_0000;
        end
    end else begin
        r.result = (sgn && !uns) ? (32'h0 - mag[31:0]) : mag[31:0];
    end
    r.flags    = '0;
    r.flags.nv = iv;
    r.flags.nx = !iv && inexact;
    return r;
endfunction

function automatic cvt_rsp_t ref_i2f(input logic [31:0] src, input logic uns,
                                     input roundmode_e rm);
    longint unsigned mag;
    longint unsigned kept;
    int              p;
    int              sh;
    int              ex;
    logic            sgn;
    logic            g;
    logic            s;
    cvt_rsp_t        r;
    sgn = !uns && src[31];
    mag = sgn ? (64'h1_0000_0000 - longint'(src)) : longint'(src);
    r   = '0;
    if (mag != 0) begin
        p = 0;
        for (int i = 0; i < 33; i++) begin
            if (mag[i]) p = i;
        end
        g = 1'b0;
        s = 1'b0;
        if (p <= 23) begin
            kept = mag << (23 - p);
        end else begin
            sh   = p - 23;
            kept = mag >> sh;
            g    = ((mag >> (sh - 1)) & 64'd1) != 0;
            s    = (mag & ((64'd1 << (sh - 1)) - 1)) != 0;
            kept = kept + longint'(model_round_up(sgn, g, s, kept[0], rm));
        end
        ex = 127 + p;
        if (kept == (64'd1 << 24)) begin
            kept = 64'd1 << 23;  // rounding carried into the next binade
            ex   = ex + 1;
        end
        r.result   = {sgn, ex[7:0], kept[22:0]};
        r.flags.nx = g | s;
    end
    return r;
endfunction

`endif

// ==== tb/fcvt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fcvt_tb;

    import fcvt_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int WAIT_LIMIT  = 4000;

    `include "fcvt_model.svh"

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    cvt_req_t    req;
    logic        req_credit;
    logic        rsp_credit;
    logic        rsp_valid;
    cvt_rsp_t    rsp;

    cvt_rsp_t    exp_mem [1024];
    cvt_rsp_t    exp_head;
    int          wr_idx;
    int          rd_idx;
    int          up_credits;
    int          held;
    int          pending;
    int          hold_left;
    int          errors;
    int          tests;
    int          sent_cnt;
    int          credit_cnt;
    logic        bp_mode;
    logic        reset_window;
    logic        timed_out;
    logic [15:0] stim_lfsr;
    logic [15:0] hold_lfsr;

    fcvt_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_credit_o (req_credit),
        .rsp_credit_i (rsp_credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_o        (rsp)
    );

    always #4 clk = ~clk;

    assign exp_head = exp_mem[rd_idx[9:0]];

    function automatic logic [31:0] rand_bits(inout logic [15:0] st, input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b  = st[0];
            st = st >> 1;
            if (b) st = st ^ 16'hB400;  // galois taps for a 16 bit register
            val = {val[30:0], b};
        end
        return val;
    endfunction

    function automatic logic [31:0] rand_float(inout logic [15:0] st);
        logic [31:0] f;
        f        = rand_bits(st, 32);
        f[30:23] = 8'd100 + 8'(rand_bits(st, 6));  // keep exponents near the integer range
        return f;
    endfunction

    // credit bookkeeping sampled like a flop
    always @(posedge clk) begin
        if (req_credit) begin
            up_credits++;
            credit_cnt++;
        end
        if (rsp_valid) begin
            rd_idx <= rd_idx + 1;
            pending++;
        end
        held <= held + int'(req_credit) - int'(rsp_credit);
    end

    initial begin
        rsp_credit = 1'b0;
        hold_left  = 0;
        forever begin
            @(posedge clk);
            #1;
            rsp_credit = 1'b0;
            if (pending > 0) begin
                if (hold_left > 0) begin
                    hold_left--;
                end else begin
                    rsp_credit = 1'b1;
                    pending--;
                    hold_left = bp_mode ? int'(rand_bits(hold_lfsr, 3)) : 0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> rd_idx != wr_idx)
        else begin
            errors++;
            $display("response at %0t with no request outstanding", $time);
        end

    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> rsp == exp_head)
        else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=rsp_o got=%h expected=%h",
                     $time, $sampled(rsp), $sampled(exp_head));
        end

    assert property (@(posedge clk) held <= OUT_CREDITS)
        else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=outstanding got=%0d expected=<=%0d",
                     $time, $sampled(held), OUT_CREDITS);
        end

    assert property (@(posedge clk) up_credits >= 0 && up_credits <= QUEUE_DEPTH)
        else begin
            errors++;
            $display("upstream credit count out of range at %0t", $time);
        end

    assert property (@(posedge clk) reset_window |-> !rsp_valid && !req_credit)
        else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=rsp_valid_o/req_credit_o got=%b%b expected=00",
                     $time, $sampled(rsp_valid), $sampled(req_credit));
        end

    task automatic send_req(input cvt_op_e op, input roundmode_e rm, input logic [31:0] src);
        int n;
        n = 0;
        while (!timed_out && up_credits == 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout while waiting for an upstream credit");
        end
        if (!timed_out) begin
            if (op == F2I_S || op == F2I_U) begin
                exp_mem[wr_idx[9:0]] = ref_f2i(src, op == F2I_U, rm);
            end else begin
                exp_mem[wr_idx[9:0]] = ref_i2f(src, op == I2F_U, rm);
            end
            wr_idx++;
            sent_cnt++;
            up_credits--;
            req_valid = 1'b1;
            req       = '{op: op, rm: rm, src: src};
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!timed_out && !(rd_idx == wr_idx && pending == 0 && held == 0) &&
               n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout while waiting for the unit to drain");
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "errors");
    endtask

    task automatic send_mixed(input int count);
        cvt_op_e     op;
        logic [31:0] src;
        for (int i = 0; i < count; i++) begin
            op  = cvt_op_e'(rand_bits(stim_lfsr, 2));
            src = (op == F2I_S || op == F2I_U) ? rand_float(stim_lfsr)
                                               : rand_bits(stim_lfsr, 32);
            send_req(op, roundmode_e'(rand_bits(stim_lfsr, 3) % 5), src);
        end
    endtask

    initial begin
        logic [31:0] int_edges [5];
        logic [31:0] flt_edges [10];
        int          errs;
        int          sent_before;
        int          credit_before;
        int_edges = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'd16777217};
        flt_edges = '{32'h7FC0_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h0, 32'h8000_0000,
                      32'h3F00_0000, 32'hBF00_0000, 32'h4020_0000, 32'h4F00_0000,
                      32'hCF00_0000};
        clk          = 1'b0;
        arst_n       = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        wr_idx       = 0;
        rd_idx       = 0;
        up_credits   = QUEUE_DEPTH;
        held         = 0;
        pending      = 0;
        errors       = 0;
        tests        = 0;
        sent_cnt     = 0;
        credit_cnt   = 0;
        bp_mode      = 1'b0;
        reset_window = 1'b1;
        timed_out    = 1'b0;
        stim_lfsr    = 16'd53581;
        hold_lfsr    = 16'd53581;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        errs = errors;
        repeat (4) @(posedge clk);
        #1;
        reset_window = 1'b0;
        report_test("reset", errs);

        errs = errors;
        for (int rm = 0; rm < 5; rm++) begin
            for (int u = 0; u < 2; u++) begin
                for (int i = 0; i < 5; i++) begin
                    send_req(u ? I2F_U : I2F_S, roundmode_e'(rm), int_edges[i]);
                end
                for (int i = 0; i < 4; i++) begin
                    send_req(u ? I2F_U : I2F_S, roundmode_e'(rm), rand_bits(stim_lfsr, 32));
                end
            end
        end
        drain();
        report_test("i2f", errs);

        errs = errors;
        for (int rm = 0; rm < 5; rm++) begin
            for (int u = 0; u < 2; u++) begin
                for (int i = 0; i < 10; i++) begin
                    send_req(u ? F2I_U : F2I_S, roundmode_e'(rm), flt_edges[i]);
                end
                for (int i = 0; i < 4; i++) begin
                    send_req(u ? F2I_U : F2I_S, roundmode_e'(rm), rand_float(stim_lfsr));
                end
            end
        end
        drain();
        report_test("f2i", errs);

        errs = errors;
        send_mixed(24);
        drain();
        report_test("ordering", errs);

        errs    = errors;
        bp_mode = 1'b1;
        send_mixed(24);
        drain();
        bp_mode = 1'b0;
        report_test("backpressure", errs);

        errs          = errors;
        sent_before   = sent_cnt;
        credit_before = credit_cnt;
        bp_mode       = 1'b1;
        send_mixed(16);
        drain();
        bp_mode = 1'b0;
        assert (credit_cnt - credit_before == sent_cnt - sent_before)
            else begin
                errors++;
                $display("CHECK FAILED time=%0t signal=req_credit_o got=%0d expected=%0d",
                         $time, credit_cnt - credit_before, sent_cnt - sent_before);
            end
        report_test("input credits", errs);

        $display("tests %0d, requests %0d, errors %0d", tests, sent_cnt, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
